// File: list.f
src/link_pkg.sv
src/link_tx_gen.sv
src/link_rx_check.sv
src/link_status.sv
src/link_top.sv
verif/tb_clock.sv
verif/link_sva.sv
verif/link_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert \
  --top-module link_tb \
  -f list.f \
  --Mdir "$OBJ" \
  -o link_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

"./$OBJ/link_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: verif/link_tb.sv
`timescale 1ns/10ps
`default_nettype none

module link_tb;

  import link_pkg::*;

  localparam int N_ROWS = 10;
  localparam int RST_CYCLES = 5;
  localparam int HB_GAP_MAX = 16;

  typedef struct {
    int cycles;
    bit en;
    int n_bad;       // 0 clean, 1 single, more for a burst
    bit clr;         // clear_loss pulse at row start
    bit exp_locked;
    int exp_err;
    bit exp_loss;    // sticky led bit 7
    bit exp_idle;    // tx_en held low so tx_word is a comma
  } row_t;

  logic       tx_pclk;
  logic       rst_n;
  logic       tx_en;
  logic       clear_loss;
  link_word_t rx_word;
  link_word_t tx_word;
  link_stat_t stat;
  logic [7:0] led;

  row_t rows [N_ROWS];
  int   cycle_count;
  int   cycle_limit;
  int   bad_left;

  // transmit monitor state
  bit        prev_en;
  int        frame_pos;
  logic [7:0] last_data;
  logic      last_hb;
  int        hb_gap;

  tb_clock #(.PERIOD_NS(20)) u_clock (.clk(tx_pclk));

  link_top #(
    .COMMA_PERIOD (8),
    .LOSS_LIMIT   (4),
    .HB_BITS      (4)
  ) uut (
    .tx_pclk    (tx_pclk),
    .rst_n      (rst_n),
    .tx_en      (tx_en),
    .clear_loss (clear_loss),
    .rx_word    (rx_word),
    .tx_word    (tx_word),
    .stat       (stat),
    .led        (led)
  );

  task automatic fail_now(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input link_word_t got, input link_word_t exp, input string what);
    if (got !== exp) begin
      fail_now($sformatf("%s: word data=%02h k=%0b, expected data=%02h k=%0b",
                         what, got.data, got.k, exp.data, exp.k));
    end
  endtask

  task automatic check_stat(input link_stat_t got, input link_stat_t exp, input string what);
    if (got.locked !== exp.locked || got.err_count !== exp.err_count) begin
      fail_now($sformatf("%s: locked=%0b err=%0d, expected locked=%0b err=%0d",
                         what, got.locked, got.err_count, exp.locked, exp.err_count));
    end
  endtask

  task automatic check_led(input logic [7:0] got, input logic [7:0] exp,
                           input logic [7:0] mask, input string what);
    if ((got & mask) !== (exp & mask)) begin
      fail_now($sformatf("%s: led=%08b, expected %08b under mask %08b",
                         what, got, exp, mask));
    end
  endtask

  // one clock of loopback with the flip mask on pending bad data words
  task automatic step_cycle();
    logic [7:0] flip;
    @(posedge tx_pclk);
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run exceeded %0d cycles", cycle_limit);
      $display("Test failed");
      $fatal(1);
    end
    if (!tx_word.k && bad_left > 0) begin
      flip = 8'(($urandom % 255) + 1);  // never zero
      rx_word <= '{data: tx_word.data ^ flip, k: 1'b0};
      bad_left--;
    end else begin
      rx_word <= tx_word;
    end
  endtask

  // expected transmit stream checked on the falling edge
  always @(negedge tx_pclk) begin
    link_word_t exp_w;
    if (rst_n) begin
      if (!prev_en) begin
        check_word(tx_word, COMMA_WORD, "idle word");
      end else begin
        if (frame_pos == 0) begin
          exp_w = COMMA_WORD;
        end else begin
          exp_w = '{data: last_data + 8'd1, k: 1'b0};
          last_data = last_data + 8'd1;
        end
        check_word(tx_word, exp_w, "framed word");
        frame_pos = (frame_pos + 1) % 8;
      end
      if (led[5] != last_hb) begin
        hb_gap = 0;
      end else begin
        hb_gap++;
      end
      last_hb = led[5];
      if (hb_gap >= HB_GAP_MAX) begin
        fail_now("heartbeat led stuck");
      end
    end
    prev_en = tx_en;
  end

  initial begin
    link_stat_t exp_s;
    logic [7:0] exp_led;
    string      tag;

    void'($urandom(16));
    rst_n      = 1'b0;
    tx_en      = 1'b0;
    clear_loss = 1'b0;
    rx_word    = COMMA_WORD;
    prev_en    = 1'b0;
    frame_pos  = 0;
    last_data  = 8'hFF;
    last_hb    = 1'b0;
    hb_gap     = 0;
    bad_left   = 0;
    cycle_count = 0;

    rows[0] = '{20, 1'b1, 0, 1'b0, 1'b1, 0, 1'b0, 1'b0};  // first lock
    rows[1] = '{10, 1'b0, 0, 1'b0, 1'b1, 0, 1'b0, 1'b1};  // idle with commas only
    rows[2] = '{20, 1'b1, 0, 1'b0, 1'b1, 0, 1'b0, 1'b0};  // resume
    rows[3] = '{20, 1'b1, 1, 1'b0, 1'b1, 1, 1'b0, 1'b0};  // single error
    rows[4] = '{20, 1'b1, 3, 1'b0, 1'b1, 4, 1'b0, 1'b0};  // burst below limit
    rows[5] = '{8, 1'b1, 4, 1'b0, 1'b0, 8, 1'b1, 1'b0};   // burst at the limit drops lock
    rows[6] = '{22, 1'b1, 0, 1'b0, 1'b1, 8, 1'b1, 1'b0};  // relock at the next comma
    rows[7] = '{20, 1'b1, 0, 1'b1, 1'b1, 8, 1'b0, 1'b0};  // clear sticky flag
    rows[8] = '{64, 1'b1, 0, 1'b0, 1'b1, 8, 1'b0, 1'b0};  // long run for heartbeat
    rows[9] = '{10, 1'b0, 0, 1'b0, 1'b1, 8, 1'b0, 1'b1};

    cycle_limit = 100 + RST_CYCLES;
    for (int i = 0; i < N_ROWS; i++) begin
      cycle_limit += rows[i].cycles;
    end

    for (int i = 0; i < RST_CYCLES; i++) begin
      step_cycle();
    end
    rst_n <= 1'b1;
    @(negedge tx_pclk);
    check_word(tx_word, COMMA_WORD, "tx_word after reset");
    check_stat(stat, '0, "stat after reset");
    check_led(led, 8'h00, 8'hFF, "led after reset");

    for (int r = 0; r < N_ROWS; r++) begin
      tag = $sformatf("row %0d", r);
      bad_left = rows[r].n_bad;
      for (int c = 0; c < rows[r].cycles; c++) begin
        step_cycle();
        if (c == 0) begin
          tx_en      <= rows[r].en;
          clear_loss <= rows[r].clr;
        end else begin
          clear_loss <= 1'b0;
        end
      end
      @(negedge tx_pclk);
      exp_s.locked    = rows[r].exp_locked;
      exp_s.lost      = 1'b0;
      exp_s.err_count = 16'(rows[r].exp_err);
      check_stat(stat, exp_s, tag);
      exp_led = {rows[r].exp_loss, rows[r].exp_locked, 1'b0,
                 (rows[r].exp_err != 0), exp_s.err_count[3:0]};
      check_led(led, exp_led, 8'hDF, tag);  // heartbeat bit checked by the monitor
      if (rows[r].exp_idle) begin
        check_word(tx_word, COMMA_WORD, tag);
      end
      if (bad_left != 0) begin
        fail_now($sformatf("%s: corruption not fully applied", tag));
      end
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/link_sva.sv
`timescale 1ns/10ps
`default_nettype none

module link_sva (
  input wire logic                  tx_pclk,
  input wire logic                  rst_n,
  input wire link_pkg::lock_state_t state,
  input wire link_pkg::link_stat_t  stat
);

  import link_pkg::*;

  // saturating counter only climbs
  err_never_drops: assert property (
    @(posedge tx_pclk) disable iff (!rst_n)
      stat.err_count >= $past(stat.err_count)
  ) else $error("err_count decreased");

  // lost is registered, so the checker was locked one cycle earlier
  lost_from_locked: assert property (
    @(posedge tx_pclk) disable iff (!rst_n)
      stat.lost |-> ($past(state) == ST_LOCKED)
  ) else $error("lost pulsed while not leaving lock");

  no_lock_after_reset: assert property (
    @(posedge tx_pclk) $rose(rst_n) |-> !stat.locked
  ) else $error("locked set right after reset");

endmodule

bind link_rx_check link_sva u_sva (
  .tx_pclk (tx_pclk),
  .rst_n   (rst_n),
  .state   (state),
  .stat    (stat)
);

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // free running, never stops
  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: src/link_top.sv
`timescale 1ns/10ps
`default_nettype none

module link_top #(
  parameter int COMMA_PERIOD = 16,
  parameter int LOSS_LIMIT   = 4,
  parameter int HB_BITS      = 24
) (
  input  wire logic                 tx_pclk,
  input  wire logic                 rst_n,
  input  wire logic                 tx_en,
  input  wire logic                 clear_loss,
  input  wire link_pkg::link_word_t rx_word,
  output link_pkg::link_word_t      tx_word,
  output link_pkg::link_stat_t      stat,
  output logic [7:0]                led
);

  // transmit framer
  link_tx_gen #(
    .COMMA_PERIOD (COMMA_PERIOD)
  ) u_tx_gen (
    .tx_pclk (tx_pclk),
    .rst_n   (rst_n),
    .tx_en   (tx_en),
    .tx_word (tx_word)
  );

  // receive side shares tx_pclk here
  link_rx_check #(
    .LOSS_LIMIT (LOSS_LIMIT)
  ) u_rx_check (
    .tx_pclk (tx_pclk),
    .rst_n   (rst_n),
    .rx_word (rx_word),
    .stat    (stat)
  );

  link_status #(
    .HB_BITS (HB_BITS)
  ) u_status (
    .tx_pclk    (tx_pclk),
    .rst_n      (rst_n),
    .clear_loss (clear_loss),
    .stat       (stat),        // same struct as the top output
    .led        (led)
  );

endmodule

`default_nettype wire

// File: src/link_status.sv
`timescale 1ns/10ps
`default_nettype none

module link_status #(
  parameter int HB_BITS = 24
) (
  input  wire logic                 tx_pclk,
  input  wire logic                 rst_n,
  input  wire logic                 clear_loss,
  input  wire link_pkg::link_stat_t stat,
  output logic [7:0]                led
);

  logic [HB_BITS-1:0] hb_count;
  logic               loss_flag;  // sticky until cleared
  logic               loss_nxt;
  logic               err_any;

  // new loss beats a clear in the same cycle
  assign loss_nxt = stat.lost | (loss_flag & ~clear_loss);
  assign err_any  = |stat.err_count;

  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      hb_count <= '0;
    end else begin
      hb_count <= hb_count + 1'b1;
    end
  end

  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      loss_flag <= 1'b0;
    end else begin
      loss_flag <= loss_nxt;
    end
  end

  // led map, msb first
  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      led <= 8'd0;
    end else begin
      led[7]   <= loss_nxt;
      led[6]   <= stat.locked;
      led[5]   <= hb_count[HB_BITS-1];  // heartbeat
      led[4]   <= err_any;
      led[3:0] <= stat.err_count[3:0];
    end
  end

endmodule

`default_nettype wire

// File: src/link_rx_check.sv
`timescale 1ns/10ps
`default_nettype none

module link_rx_check #(
  parameter int LOSS_LIMIT = 4
) (
  input  wire logic                 tx_pclk,
  input  wire logic                 rst_n,
  input  wire link_pkg::link_word_t rx_word,
  output link_pkg::link_stat_t      stat
);

  import link_pkg::*;

  localparam int RUN_W = $clog2(LOSS_LIMIT + 1);
  localparam logic [RUN_W-1:0] RUN_LAST = RUN_W'(LOSS_LIMIT - 1);

  lock_state_t      state;
  lock_state_t      state_nxt;
  logic             comma_seen;  // last word was a comma while hunting
  logic [7:0]       expected;
  logic [RUN_W-1:0] bad_run;
  logic [ERR_W-1:0] err_count;
  logic             lost;

  logic rx_comma;
  logic rx_data;
  logic locked_data;
  logic mismatch;
  logic run_done;

  assign rx_comma    = is_comma(rx_word);
  assign rx_data     = is_data(rx_word);
  assign locked_data = (state == ST_LOCKED) && rx_data;
  assign mismatch    = locked_data && (rx_word.data != expected);
  assign run_done    = mismatch && (bad_run == RUN_LAST);  // this word ends the bad run

  always_comb begin
    state_nxt = state;
    case (state)
      ST_HUNT: begin
        if (rx_data && comma_seen) begin
          state_nxt = ST_LOCKED;
        end
      end
      ST_LOCKED: begin
        if (run_done) begin
          state_nxt = ST_HUNT;
        end
      end
      default: state_nxt = ST_HUNT;
    endcase
  end

  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      state <= ST_HUNT;
    end else begin
      state <= state_nxt;
    end
  end

  // comma then data locks and stray control chars leave it alone
  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      comma_seen <= 1'b0;
    end else if (state == ST_HUNT) begin
      if (rx_comma) begin
        comma_seen <= 1'b1;
      end else if (rx_data) begin
        comma_seen <= 1'b0;
      end
    end else begin
      comma_seen <= 1'b0;
    end
  end

  // seeded by every hunt data word so the locking word sets it
  always_ff @(posedge tx_pclk) begin
    if (rx_data) begin
      if (state == ST_HUNT) begin
        expected <= rx_word.data + 8'd1;
      end else begin
        expected <= expected + 8'd1;  // moves on even after a miss
      end
    end
  end

  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      bad_run <= '0;
    end else if (run_done) begin
      bad_run <= '0;
    end else if (mismatch) begin
      bad_run <= bad_run + 1'b1;
    end else if (locked_data) begin
      bad_run <= '0;  // a good word breaks the run
    end
  end

  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      err_count <= '0;
      lost      <= 1'b0;
    end else begin
      lost <= run_done;
      if (mismatch && err_count != ERR_MAX) begin
        err_count <= err_count + 1'b1;
      end
    end
  end

  assign stat.locked    = (state == ST_LOCKED);
  assign stat.lost      = lost;
  assign stat.err_count = err_count;

endmodule

`default_nettype wire

// File: src/link_tx_gen.sv
`timescale 1ns/10ps
`default_nettype none

module link_tx_gen #(
  parameter int COMMA_PERIOD = 16
) (
  input  wire logic             tx_pclk,
  input  wire logic             rst_n,
  input  wire logic             tx_en,
  output link_pkg::link_word_t  tx_word
);

  import link_pkg::*;

  localparam int SLOT_W = $clog2(COMMA_PERIOD);
  localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(COMMA_PERIOD - 1);

  logic [SLOT_W-1:0] slot;       // position inside the frame
  logic [7:0]        seq;        // next sequence byte to send
  logic              slot_zero;
  logic              send_data;

  assign slot_zero = (slot == '0);
  assign send_data = tx_en && !slot_zero;

  // frame slot counter, frozen while idle
  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      slot <= '0;
    end else if (tx_en) begin
      if (slot == SLOT_LAST) begin
        slot <= '0;
      end else begin
        slot <= slot + 1'b1;
      end
    end
  end

  // advances only on data slots
  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      seq <= 8'd0;
    end else if (send_data) begin
      seq <= seq + 8'd1;  // wraps at 255
    end
  end

  // output word register, comma on slot 0 and while idle
  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      tx_word <= COMMA_WORD;
    end else if (send_data) begin
      tx_word.data <= seq;
      tx_word.k    <= 1'b0;
    end else begin
      tx_word <= COMMA_WORD;
    end
  end

endmodule

`default_nettype wire

// File: src/link_pkg.sv
`default_nettype none

package link_pkg;

  localparam int ERR_W = 16;

  // error counter stops here
  localparam logic [ERR_W-1:0] ERR_MAX = '1;

  // K28.5, always sent with k set
  localparam logic [7:0] COMMA_BYTE = 8'hBC;

  typedef struct packed {
    logic [7:0] data;
    logic       k;      // control character when set
  } link_word_t;

  typedef struct packed {
    logic             locked;
    logic             lost;       // one cycle when lock drops
    logic [ERR_W-1:0] err_count;  // saturating
  } link_stat_t;

  typedef enum logic {
    ST_HUNT   = 1'b0,
    ST_LOCKED = 1'b1
  } lock_state_t;

  localparam link_word_t COMMA_WORD = '{data: COMMA_BYTE, k: 1'b1};

  function automatic logic is_comma(input link_word_t w);
    return w.k && (w.data == COMMA_BYTE);
  endfunction

  // other control characters are neither comma nor data
  function automatic logic is_data(input link_word_t w);
    return !w.k;
  endfunction

endpackage

`default_nettype wire
